//--- verilog.f
+incdir+verification
verilog/phx_value_pkg.sv
verilog/phx_isa_pkg.sv
verilog/phx_int_unit.sv
verilog/phx_fp_unit.sv
verilog/phx_alu.sv
verification/tb_clkgen.sv
verification/phx_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module phx_alu_tb -o phx_alu_sim

./obj_dir/phx_alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- verification/phx_alu_ref.svh
`ifndef PHX_ALU_REF_SVH
`define PHX_ALU_REF_SVH

// ============================================================================
// expected results, one instruction at a time
// ============================================================================

// integer compare vector, signed order taken as unsigned order of the
// operands with their sign bits flipped
function automatic value_t int_compare_vec(input value_t a, input value_t b);
	value_t ka;
	value_t kb;
	value_t v;
	ka = a ^ 32'h8000_0000;
	kb = b ^ 32'h8000_0000;
	v = '0;	// unused bits read zero
	v[CMP_EQ]  = (a == b);
	v[CMP_NE]  = (a != b);
	v[CMP_LT]  = (ka < kb);
	v[CMP_LE]  = !(kb < ka);
	v[CMP_GE]  = !(ka < kb);
	v[CMP_GT]  = (kb < ka);
	v[CMP_LTU] = (a < b);
	v[CMP_LEU] = !(b < a);
	v[CMP_GEU] = !(a < b);
	v[CMP_GTU] = (b < a);
	return v;
endfunction

function automatic logic float_is_nan(input value_t x);
	return (x[30:23] == 8'hFF) && (x[22:0] != '0);
endfunction

// maps a float onto an unsigned key with the same order, both zeros
// land on one key
function automatic value_t float_order_key(input value_t x);
	if (x[30:0] == '0)
		return 32'h8000_0000;
	else if (x[31])
		return ~x;	// negative, bigger magnitude gives a smaller key
	else
		return x | 32'h8000_0000;
endfunction

function automatic value_t float_order_vec(input value_t a, input value_t b);
	value_t ka;
	value_t kb;
	value_t v;
	logic   eq;
	logic   lt;
	ka = float_order_key(a);
	kb = float_order_key(b);
	eq = (ka == kb);
	lt = (ka < kb);
	v = '0;
	if (float_is_nan(a) || float_is_nan(b))
		v[FCMP_UNE] = 1'b1;	// unordered, nothing else set
	else
	begin
		v[FCMP_EQ]  = eq;
		v[FCMP_LT]  = lt;
		v[FCMP_LE]  = lt | eq;
		v[FCMP_UNE] = !eq;
		v[FCMP_GE]  = !lt;
		v[FCMP_GT]  = !lt && !eq;
		v[FCMP_MGE] = (a[30:0] >= b[30:0]);	// magnitudes only
		v[FCMP_ORD] = 1'b1;
	end
	return v;
endfunction

function automatic value_t float_class_vec(input value_t x);
	logic        s;
	logic [7:0]  e;
	logic [22:0] f;
	value_t      v;
	s = x[31];
	e = x[30:23];
	f = x[22:0];
	v = '0;
	v[31] = s;
	v[1]  = s;
	v[6]  = !s;
	if (e == 8'hFF && f != '0)
		v[f[22] ? 9 : 8] = 1'b1;	// quiet or signalling
	else if (e == 8'hFF)
		v[s ? 0 : 7] = 1'b1;	// infinity
	else if (e == 8'h00 && f == '0)
		v[s ? 3 : 4] = 1'b1;	// zero
	else if (e == 8'h00)
		v[s ? 2 : 5] = 1'b1;	// subnormal
	return v;
endfunction

function automatic value_t phx_alu_ref(input value_t ir, input value_t a, input value_t b,
	input value_t imm);
	logic [5:0] opc;
	logic [5:0] fn;
	logic [3:0] sel;
	value_t     r;
	logic       cmp;	// result is a compare vector
	int         n;
	logic       hit;
	opc = ir[OPC_MSB:OPC_LSB];
	fn  = ir[FUNC_MSB:FUNC_LSB];
	sel = ir[SEL_MSB:SEL_LSB];
	r   = '0;	// undefined encodings stay zero
	cmp = 1'b0;
	case (opc)
	OP_R2:
		case (fn)
		F_ADD:     r = a + b;
		F_SUB:     r = a - b;
		F_AND:     r = a & b;
		F_OR:      r = a | b;
		F_XOR:     r = a ^ b;
		F_SLL:     r = a << b[4:0];
		F_SRL:     r = a >> b[4:0];
		F_SRA:     r = value_t'($signed(a) >>> b[4:0]);
		F_SLLI:    r = a << imm[4:0];
		F_SRLI:    r = a >> imm[4:0];
		F_SRAI:    r = value_t'($signed(a) >>> imm[4:0]);
		F_CMP:
		begin
			r   = int_compare_vec(a, b);
			cmp = 1'b1;
		end
		F_FCMP:
		begin
			r   = float_order_vec(a, b);
			cmp = 1'b1;
		end
		F_CNTLZ:
		begin
			n   = 0;
			hit = 1'b0;
			for (int i = XLEN - 1; i >= 0; i--)
			begin
				hit = hit | a[i];
				if (!hit)
					n++;	// zeros above the first one
			end
			r = value_t'(n);
		end
		F_CNTPOP:  r = value_t'($countones(a));
		F_SEXTB:   r = {{24{a[7]}}, a[7:0]};
		F_SEXTW:   r = {{16{a[15]}}, a[15:0]};
		F_FABS:    r = a & 32'h7FFF_FFFF;
		F_FNABS:   r = a | 32'h8000_0000;
		F_FNEG:    r = a ^ 32'h8000_0000;
		F_FCLASS:  r = float_class_vec(a);
		F_FSIGN:   r = (a[30:0] == '0) ? 32'h0 : (a[31] ? 32'hBF80_0000 : 32'h3F80_0000);
		F_FFINITE: r = (a[30:23] != 8'hFF) ? 32'd1 : 32'd0;
		default:   r = '0;
		endcase
	OP_ADDI:  r = a + imm;
	OP_SUBFI: r = imm - a;
	OP_ANDI:  r = a & imm;
	OP_ORI:   r = a | imm;
	OP_XORI:  r = a ^ imm;
	OP_CMPI:
	begin
		r   = int_compare_vec(a, imm);
		cmp = 1'b1;
	end
	OP_FCMPI:
	begin
		r   = float_order_vec(a, imm);
		cmp = 1'b1;
	end
	default:  r = '0;
	endcase
	if (cmp && sel != SEL_ALL)
		r = {{31{1'b0}}, r[sel]};	// single bit
	return r;
endfunction

`endif

//--- verification/phx_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module phx_alu_tb
	import phx_value_pkg::*, phx_isa_pkg::*;
();

	// instructions issued by each test
	localparam int N_LATENCY   = 12;
	localparam int N_ARITH     = 506;
	localparam int N_SHIFT     = 216;
	localparam int N_ICMP      = 96;
	localparam int N_FLOAT     = 316;
	localparam int N_UNDEF     = 8;
	localparam int N_TOTAL     = N_LATENCY + N_ARITH + N_SHIFT + N_ICMP + N_FLOAT + N_UNDEF;
	localparam int CYCLE_LIMIT = 2 * N_TOTAL + 100;

	logic   clk;
	logic   rst_n;
	logic   issue_valid;
	value_t ir, opa, opb, imm;
	value_t result;
	logic   result_valid;

	value_t exp_q [$];	// expected results, oldest first
	string  name_q [$];	// test that issued each entry
	string  cur_test;
	value_t exp_val;
	string  exp_name;
	int     errors = 0;	// checker only
	int     reset_errors = 0;	// main process only
	int     checks = 0;
	int     issued = 0;
	int     cycles = 0;
	int     test_err0, test_chk0;
	logic   issued_last = 1'b0;	// valid_i seen by the last rising edge
	value_t va, vb;
	value_t fp_vals [10];
	value_t fa [8], fb [8];	// float compare pairs
	value_t ca [3], cb [3];	// integer compare pairs
	value_t edge_vals [4];
	value_t sext_vals [4];

	`include "phx_alu_ref.svh"

	tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

	phx_alu dut_i (
		.clk_i(clk), .rst_n_i(rst_n), .valid_i(issue_valid), .ir_i(ir),
		.a_i(opa), .b_i(opb), .imm_i(imm), .result_o(result), .valid_o(result_valid)
	);

	// ========================================================================
	// stimulus helpers
	// ========================================================================
	task automatic issue(input logic [5:0] opc, input logic [5:0] fn, input logic [3:0] sel,
		input value_t a, input value_t b, input value_t im);
		@(negedge clk);
		ir          = {16'h0000, sel, fn, opc};
		opa         = a;
		opb         = b;
		imm         = im;
		issue_valid = 1'b1;
		exp_q.push_back(phx_alu_ref(ir, a, b, im));
		name_q.push_back(cur_test);
		issued++;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge clk);
			issue_valid = 1'b0;
		end
	endtask

	task automatic random_arith();
		logic [5:0] r2_fn [5];
		logic [5:0] imm_opc [5];
		int         k;
		r2_fn   = '{F_ADD, F_SUB, F_AND, F_OR, F_XOR};
		imm_opc = '{OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI};
		k = $urandom_range(9, 0);
		if (k < 5)
			issue(OP_R2, r2_fn[k], '0, $urandom(), $urandom(), $urandom());
		else
			issue(imm_opc[k-5], '0, '0, $urandom(), $urandom(), $urandom());
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_err0 = errors + reset_errors;
		test_chk0 = checks;
	endtask

	// let the pipe drain, then one line for the test
	task automatic end_test();
		idle(1);
		while (exp_q.size() != 0)
			@(negedge clk);
		$display("%s: %0d checks, %0d errors", cur_test, checks - test_chk0,
			errors + reset_errors - test_err0);
	endtask

	// ========================================================================
	// scoreboard, sampled on the falling edge where outputs are settled
	// ========================================================================
	always @(posedge clk)
		issued_last <= issue_valid;

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			assert (result_valid == issued_last)
			else
			begin
				$display("ERROR: valid_o was %b one cycle after valid_i was %b",
					result_valid, issued_last);
				errors++;
			end
			if (result_valid)
			begin
				assert (exp_q.size() != 0)
				else
				begin
					$display("ERROR: valid_o high with no instruction outstanding");
					errors++;
				end
				if (exp_q.size() != 0)
				begin
					exp_val  = exp_q.pop_front();
					exp_name = name_q.pop_front();
					checks++;
					assert (result === exp_val)
					else
					begin
						$display("CHECK FAILED %s: expected %h, actual %h",
							exp_name, exp_val, result);
						errors++;
					end
				end
			end
		end
	end

	// watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("ERROR: timeout, run still going after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// ========================================================================
	// tests
	// ========================================================================
	initial
	begin
		issue_valid = 1'b0;
		ir          = '0;
		opa         = '0;
		opb         = '0;
		imm         = '0;
		void'($urandom(32'hccc6_ee9b));
		fp_vals   = '{32'h0000_0000, 32'h8000_0000, 32'h0040_0000, 32'h8000_0ABC,
			32'h3FC0_0000, 32'hC120_0000, 32'h7F80_0000, 32'hFF80_0000,
			32'h7FC0_0001, 32'h7F80_0001};	// +-0, +-sub, +-norm, +-inf, qnan, snan
		fa        = '{32'h0000_0000, 32'h3F80_0000, 32'h4000_0000, 32'hBF80_0000,
			32'hC000_0000, 32'h3FC0_0000, 32'h7FC0_0000, 32'h3F80_0000};
		fb        = '{32'h8000_0000, 32'h4000_0000, 32'h3F80_0000, 32'hC000_0000,
			32'h3F80_0000, 32'h3FC0_0000, 32'h3F80_0000, 32'h7F80_0001};
		ca        = '{32'h0000_0005, 32'h0000_0010, 32'hFFFF_FFF0};	// eq, sgt, ugt
		cb        = '{32'h0000_0005, 32'hFFFF_FFF0, 32'h0000_0010};
		edge_vals = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000};
		sext_vals = '{32'hFFFF_FF7F, 32'h0000_0080, 32'h1234_8000, 32'hABCD_7FFF};
		@(posedge rst_n);

		start_test("latency");
		assert (result_valid === 1'b0 && result === '0)
		else
		begin
			$display("ERROR: valid_o or result_o not low after reset");
			reset_errors++;
		end
		for (int i = 0; i < 8; i++)
			issue(OP_R2, F_ADD, '0, $urandom(), $urandom(), '0);	// back to back
		for (int i = 0; i < 4; i++)
		begin
			issue(OP_ADDI, '0, '0, $urandom(), '0, $urandom());
			idle(i + 1);	// growing gaps
		end
		end_test();

		start_test("int_arith");
		issue(OP_R2, F_ADD, '0, 32'h7FFF_FFFF, 32'h1, '0);	// signed overflow
		issue(OP_R2, F_ADD, '0, 32'hFFFF_FFFF, 32'h1, '0);	// carry out
		issue(OP_R2, F_SUB, '0, 32'h0, 32'h1, '0);
		issue(OP_R2, F_SUB, '0, 32'h8000_0000, 32'h1, '0);
		issue(OP_SUBFI, '0, '0, 32'h1, 32'h0, 32'h0);
		issue(OP_ADDI, '0, '0, 32'hFFFF_FFFF, 32'h0, 32'hFFFF_FFFF);
		for (int i = 0; i < 500; i++)
			random_arith();
		end_test();

		start_test("shift_count");
		for (int s = 0; s < 32; s++)
		begin
			va     = $urandom();
			va[31] = s[0];	// alternate the sign for sra
			vb     = ($urandom() << 5) | value_t'(s);	// junk above the amount
			issue(OP_R2, F_SLL, '0, va, vb, $urandom());
			issue(OP_R2, F_SRL, '0, va, vb, $urandom());
			issue(OP_R2, F_SRA, '0, va, vb, $urandom());
			issue(OP_R2, F_SLLI, '0, va, $urandom(), vb);
			issue(OP_R2, F_SRLI, '0, va, $urandom(), vb);
			issue(OP_R2, F_SRAI, '0, va, $urandom(), vb);
		end
		for (int i = 0; i < 8; i++)
		begin
			va = (i < 4) ? edge_vals[i] : ($urandom() >> (3 * i));
			issue(OP_R2, F_CNTLZ, '0, va, '0, '0);
			issue(OP_R2, F_CNTPOP, '0, va, '0, '0);
		end
		for (int i = 0; i < 4; i++)
		begin
			issue(OP_R2, F_SEXTB, '0, sext_vals[i], '0, '0);
			issue(OP_R2, F_SEXTW, '0, sext_vals[i], '0, '0);
		end
		end_test();

		start_test("int_compare");
		for (int p = 0; p < 3; p++)
			for (int s = 0; s < 16; s++)
			begin
				issue(OP_R2, F_CMP, 4'(s), ca[p], cb[p], $urandom());
				issue(OP_CMPI, '0, 4'(s), ca[p], $urandom(), cb[p]);
			end
		end_test();

		start_test("float");
		for (int i = 0; i < 10; i++)
		begin
			issue(OP_R2, F_FCLASS, '0, fp_vals[i], '0, '0);
			issue(OP_R2, F_FABS, '0, fp_vals[i], '0, '0);
			issue(OP_R2, F_FNABS, '0, fp_vals[i], '0, '0);
			issue(OP_R2, F_FNEG, '0, fp_vals[i], '0, '0);
			issue(OP_R2, F_FSIGN, '0, fp_vals[i], '0, '0);
			issue(OP_R2, F_FFINITE, '0, fp_vals[i], '0, '0);
		end
		for (int p = 0; p < 8; p++)
			for (int s = 0; s < 16; s++)
			begin
				issue(OP_R2, F_FCMP, 4'(s), fa[p], fb[p], $urandom());
				issue(OP_FCMPI, '0, 4'(s), fa[p], $urandom(), fb[p]);
			end
		end_test();

		start_test("undefined");
		issue(6'h00, 6'(F_ADD), '0, $urandom(), $urandom(), $urandom());
		issue(6'h01, '0, '0, $urandom(), $urandom(), $urandom());
		issue(6'h3F, '0, '0, $urandom(), $urandom(), $urandom());
		issue(6'h10, '0, '0, $urandom(), $urandom(), $urandom());
		issue(OP_R2, 6'h00, '0, $urandom(), $urandom(), $urandom());
		issue(OP_R2, 6'h3F, '0, $urandom(), $urandom(), $urandom());
		issue(OP_R2, 6'h13, '0, $urandom(), $urandom(), $urandom());
		issue(OP_R2, 6'h2E, '0, $urandom(), $urandom(), $urandom());
		end_test();

		$display("summary: %0d issued, %0d checked, %0d errors", issued, checks,
			errors + reset_errors);
		if (errors + reset_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_PERIOD  = 20;	// 40 ns period
	localparam int RESET_CYCLES = 3;

	initial
	begin
		clk_o = 1'b0;
		forever
			#HALF_PERIOD clk_o = ~clk_o;
	end

	// reset low from time zero, let go on a falling edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/phx_alu.sv
`timescale 1ns/1ps
`default_nettype none

module phx_alu
	import phx_value_pkg::*, phx_isa_pkg::*;
(
	input  wire logic   clk_i,
	input  wire logic   rst_n_i,
	input  wire logic   valid_i,	// issue strobe
	input  wire value_t ir_i,	// instruction word
	input  wire value_t a_i,
	input  wire value_t b_i,
	input  wire value_t imm_i,
	output value_t      result_o,
	output logic        valid_o	// one cycle after valid_i
);

	typedef enum logic [1:0] {UNIT_NONE, UNIT_INT, UNIT_FP} unit_e;

	opcode_e    opc;
	func_e      func;
	logic [3:0] sel;	// compare bit select field
	unit_e      unit;
	logic       is_cmp;	// result is a compare vector
	int_op_e    iop;
	fp_op_e     fop;
	value_t     int_a, int_b, fp_b;
	value_t     int_res, fp_res, unit_res, next_res;

	assign opc  = opcode_e'(ir_i[OPC_MSB:OPC_LSB]);
	assign func = func_e'(ir_i[FUNC_MSB:FUNC_LSB]);
	assign sel  = ir_i[SEL_MSB:SEL_LSB];

	// ========================================================================
	// decode
	// ========================================================================
	always_comb
	begin
		unit   = UNIT_NONE;	// undefined encodings end up as zero
		is_cmp = 1'b0;
		iop    = IOP_ADD;
		fop    = FOP_ABS;
		int_a  = a_i;
		int_b  = b_i;
		fp_b   = b_i;
		case (opc)
		OP_R2:
			case (func)
			F_ADD:     begin unit = UNIT_INT; iop = IOP_ADD; end
			F_SUB:     begin unit = UNIT_INT; iop = IOP_SUB; end
			F_AND:     begin unit = UNIT_INT; iop = IOP_AND; end
			F_OR:      begin unit = UNIT_INT; iop = IOP_OR; end
			F_XOR:     begin unit = UNIT_INT; iop = IOP_XOR; end
			F_SLL:     begin unit = UNIT_INT; iop = IOP_SLL; end
			F_SRL:     begin unit = UNIT_INT; iop = IOP_SRL; end
			F_SRA:     begin unit = UNIT_INT; iop = IOP_SRA; end
			F_SLLI:    begin unit = UNIT_INT; iop = IOP_SLL; int_b = imm_i; end
			F_SRLI:    begin unit = UNIT_INT; iop = IOP_SRL; int_b = imm_i; end
			F_SRAI:    begin unit = UNIT_INT; iop = IOP_SRA; int_b = imm_i; end
			F_CMP:     begin unit = UNIT_INT; iop = IOP_CMP; is_cmp = 1'b1; end
			F_FCMP:    begin unit = UNIT_FP; fop = FOP_CMP; is_cmp = 1'b1; end
			F_CNTLZ:   begin unit = UNIT_INT; iop = IOP_CNTLZ; end
			F_CNTPOP:  begin unit = UNIT_INT; iop = IOP_CNTPOP; end
			F_SEXTB:   begin unit = UNIT_INT; iop = IOP_SEXTB; end
			F_SEXTW:   begin unit = UNIT_INT; iop = IOP_SEXTW; end
			F_FABS:    begin unit = UNIT_FP; fop = FOP_ABS; end
			F_FNABS:   begin unit = UNIT_FP; fop = FOP_NABS; end
			F_FNEG:    begin unit = UNIT_FP; fop = FOP_NEG; end
			F_FCLASS:  begin unit = UNIT_FP; fop = FOP_CLASS; end
			F_FSIGN:   begin unit = UNIT_FP; fop = FOP_SIGN; end
			F_FFINITE: begin unit = UNIT_FP; fop = FOP_FINITE; end
			default:   unit = UNIT_NONE;
			endcase
		OP_ADDI:  begin unit = UNIT_INT; iop = IOP_ADD; int_b = imm_i; end
		OP_SUBFI: begin unit = UNIT_INT; iop = IOP_SUB; int_a = imm_i; int_b = a_i; end	// imm - a
		OP_ANDI:  begin unit = UNIT_INT; iop = IOP_AND; int_b = imm_i; end
		OP_ORI:   begin unit = UNIT_INT; iop = IOP_OR; int_b = imm_i; end
		OP_XORI:  begin unit = UNIT_INT; iop = IOP_XOR; int_b = imm_i; end
		OP_CMPI:  begin unit = UNIT_INT; iop = IOP_CMP; int_b = imm_i; is_cmp = 1'b1; end
		OP_FCMPI: begin unit = UNIT_FP; fop = FOP_CMP; fp_b = imm_i; is_cmp = 1'b1; end
		default:  unit = UNIT_NONE;
		endcase
	end

	phx_int_unit u_int (.op_i(iop), .a_i(int_a), .b_i(int_b), .result_o(int_res));

	phx_fp_unit u_fp (.op_i(fop), .a_i(a_i), .b_i(fp_b), .result_o(fp_res));

	// pick a unit, then narrow a compare vector to one bit unless SEL_ALL
	always_comb
	begin
		case (unit)
		UNIT_INT: unit_res = int_res;
		UNIT_FP:  unit_res = fp_res;
		default:  unit_res = '0;
		endcase
		if (is_cmp && sel != SEL_ALL)
			next_res = {{(XLEN-1){1'b0}}, unit_res[sel]};	// zero extended bit
		else
			next_res = unit_res;
	end

	// ========================================================================
	// output register, one cycle latency
	// ========================================================================
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			valid_o  <= 1'b0;
			result_o <= '0;
		end
		else
		begin
			valid_o <= valid_i;
			if (valid_i)
				result_o <= next_res;	// held between issues
		end
	end

endmodule

`default_nettype wire

//--- verilog/phx_fp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module phx_fp_unit
	import phx_value_pkg::*, phx_isa_pkg::*;
(
	input  wire fp_op_e op_i,	// operation to perform
	input  wire value_t a_i,
	input  wire value_t b_i,	// register or immediate, compare only
	output value_t      result_o
);

	value_t opnd [2];	// 0 is a, 1 is b

	// decomposed fields, one entry per operand
	logic [1:0] sgn;
	logic [1:0] exp_zero;	// exponent all zeros
	logic [1:0] exp_ones;	// exponent all ones
	logic [1:0] frac_zero;
	logic [1:0] is_zero;
	logic [1:0] is_sub;	// subnormal
	logic [1:0] is_inf;
	logic [1:0] is_nan;
	logic [1:0] is_qnan;
	logic [1:0] is_snan;

	value_t class_vec;
	value_t fcmp_vec;
	logic   any_nan;
	logic   both_zero;
	logic   mag_lt;	// |a| < |b|
	logic   mag_ge;
	logic   raw_eq;	// before nan masking
	logic   raw_lt;

	// ========================================================================
	// decomposition
	// ========================================================================
	assign opnd[0] = a_i;
	assign opnd[1] = b_i;

	for (genvar k = 0; k < 2; k++)
	begin : g_decomp
		assign sgn[k]       = opnd[k][XLEN-1];
		assign exp_zero[k]  = opnd[k][XLEN-2 -: EXP_W] == '0;
		assign exp_ones[k]  = &opnd[k][XLEN-2 -: EXP_W];
		assign frac_zero[k] = opnd[k][FRAC_W-1:0] == '0;
		assign is_zero[k]   = exp_zero[k] & frac_zero[k];
		assign is_sub[k]    = exp_zero[k] & ~frac_zero[k];
		assign is_inf[k]    = exp_ones[k] & frac_zero[k];
		assign is_nan[k]    = exp_ones[k] & ~frac_zero[k];
		assign is_qnan[k]   = is_nan[k] & opnd[k][FRAC_W-1];	// top fraction bit set
		assign is_snan[k]   = is_nan[k] & ~opnd[k][FRAC_W-1];
	end

	// ========================================================================
	// classification of a
	// ========================================================================
	always_comb
	begin
		class_vec = '0;
		class_vec[0]      = sgn[0] & is_inf[0];	// -inf
		class_vec[1]      = sgn[0];	// negative
		class_vec[2]      = sgn[0] & is_sub[0];
		class_vec[3]      = sgn[0] & is_zero[0];	// -0
		class_vec[4]      = ~sgn[0] & is_zero[0];	// +0
		class_vec[5]      = ~sgn[0] & is_sub[0];
		class_vec[6]      = ~sgn[0];	// positive
		class_vec[7]      = ~sgn[0] & is_inf[0];	// +inf
		class_vec[8]      = is_snan[0];
		class_vec[9]      = is_qnan[0];
		class_vec[XLEN-1] = sgn[0];	// sign copied to the top
	end

	// ========================================================================
	// compare, sign-magnitude with nan and signed zero handling
	// ========================================================================
	assign any_nan   = |is_nan;
	assign both_zero = &is_zero;	// +0 == -0
	assign mag_lt    = a_i[XLEN-2:0] < b_i[XLEN-2:0];
	assign mag_ge    = ~mag_lt;
	assign raw_eq    = (a_i == b_i) | both_zero;

	always_comb
	begin
		if (both_zero)
			raw_lt = 1'b0;
		else if (sgn[0] != sgn[1])
			raw_lt = sgn[0];	// negative a below positive b
		else if (!sgn[0])
			raw_lt = mag_lt;	// both positive
		else
			raw_lt = ~mag_lt & (a_i != b_i);	// both negative, larger magnitude is lower
	end

	always_comb
	begin
		fcmp_vec = '0;
		fcmp_vec[FCMP_EQ]  = ~any_nan & raw_eq;
		fcmp_vec[FCMP_LT]  = ~any_nan & raw_lt;
		fcmp_vec[FCMP_LE]  = ~any_nan & (raw_lt | raw_eq);
		fcmp_vec[FCMP_UNE] = any_nan | ~raw_eq;	// only bit set on a nan
		fcmp_vec[FCMP_GE]  = ~any_nan & ~raw_lt;
		fcmp_vec[FCMP_GT]  = ~any_nan & ~raw_lt & ~raw_eq;
		fcmp_vec[FCMP_MGE] = ~any_nan & mag_ge;
		fcmp_vec[FCMP_ORD] = ~any_nan;
	end

	// ========================================================================
	// result select
	// ========================================================================
	always_comb
	begin
		case (op_i)
		FOP_ABS:    result_o = {1'b0, a_i[XLEN-2:0]};
		FOP_NABS:   result_o = {1'b1, a_i[XLEN-2:0]};
		FOP_NEG:    result_o = {~a_i[XLEN-1], a_i[XLEN-2:0]};
		FOP_CLASS:  result_o = class_vec;
		FOP_SIGN:   result_o = is_zero[0] ? '0 : (sgn[0] ? FP_NEG_ONE : FP_ONE);
		FOP_FINITE: result_o = {{(XLEN-1){1'b0}}, ~exp_ones[0]};	// nan and inf fail
		FOP_CMP:    result_o = fcmp_vec;
		default:    result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/phx_int_unit.sv
`timescale 1ns/1ps
`default_nettype none

module phx_int_unit
	import phx_value_pkg::*, phx_isa_pkg::*;
(
	input  wire int_op_e op_i,	// operation to perform
	input  wire value_t  a_i,
	input  wire value_t  b_i,	// already muxed: register or immediate
	output value_t       result_o
);

	logic [SHIFT_W-1:0] shamt;	// low bits of b only
	dvalue_t sll_d;
	dvalue_t srl_d;
	dvalue_t sra_d;
	count_t  lz_cnt;
	count_t  pop_cnt;
	value_t  cmp_vec;

	// ========================================================================
	// shifter
	// ========================================================================
	// the operand sits in one half of a double width word and the fill
	// in the other, the wanted half is picked afterwards
	assign shamt = b_i[SHIFT_W-1:0];

	always_comb
		sll_d = {a_i, {XLEN{1'b0}}} << shamt;	// result in upper half

	always_comb
		srl_d = {{XLEN{1'b0}}, a_i} >> shamt;	// result in lower half

	always_comb
		sra_d = {{XLEN{a_i[XLEN-1]}}, a_i} >> shamt;	// sign copies shift in

	// ========================================================================
	// counters
	// ========================================================================
	always_comb
	begin
		lz_cnt = count_t'(XLEN);	// all zero operand
		for (int i = 0; i < XLEN; i++)
			if (a_i[i])
				lz_cnt = count_t'(XLEN - 1 - i);	// highest set bit wins
	end

	always_comb
	begin
		pop_cnt = '0;
		for (int i = 0; i < XLEN; i++)
			pop_cnt = pop_cnt + count_t'(a_i[i]);
	end

	// ========================================================================
	// compare vector
	// ========================================================================
	always_comb
	begin
		cmp_vec = '0;	// unused positions stay clear
		cmp_vec[CMP_EQ]  = a_i == b_i;
		cmp_vec[CMP_LT]  = $signed(a_i) <  $signed(b_i);
		cmp_vec[CMP_LE]  = $signed(a_i) <= $signed(b_i);
		cmp_vec[CMP_LTU] = a_i <  b_i;
		cmp_vec[CMP_LEU] = a_i <= b_i;
		cmp_vec[CMP_NE]  = a_i != b_i;
		cmp_vec[CMP_GE]  = $signed(a_i) >= $signed(b_i);
		cmp_vec[CMP_GT]  = $signed(a_i) >  $signed(b_i);
		cmp_vec[CMP_GEU] = a_i >= b_i;
		cmp_vec[CMP_GTU] = a_i >  b_i;
	end

	// ========================================================================
	// result select
	// ========================================================================
	always_comb
	begin
		case (op_i)
		IOP_ADD:    result_o = a_i + b_i;
		IOP_SUB:    result_o = a_i - b_i;	// subfi arrives with operands swapped
		IOP_AND:    result_o = a_i & b_i;
		IOP_OR:     result_o = a_i | b_i;
		IOP_XOR:    result_o = a_i ^ b_i;
		IOP_SLL:    result_o = sll_d[2*XLEN-1:XLEN];
		IOP_SRL:    result_o = srl_d[XLEN-1:0];
		IOP_SRA:    result_o = sra_d[XLEN-1:0];
		IOP_CMP:    result_o = cmp_vec;	// bit select is done in the top level
		IOP_CNTLZ:  result_o = {{(XLEN-CNT_W){1'b0}}, lz_cnt};
		IOP_CNTPOP: result_o = {{(XLEN-CNT_W){1'b0}}, pop_cnt};
		IOP_SEXTB:  result_o = {{(XLEN-8){a_i[7]}}, a_i[7:0]};
		IOP_SEXTW:  result_o = {{(XLEN-16){a_i[15]}}, a_i[15:0]};
		default:    result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/phx_isa_pkg.sv
`default_nettype none

package phx_isa_pkg;

	// ========================================================================
	// instruction word fields
	// ========================================================================
	localparam int unsigned OPC_LSB  = 0;
	localparam int unsigned OPC_MSB  = 5;
	localparam int unsigned FUNC_LSB = 6;	// sub-function under OP_R2
	localparam int unsigned FUNC_MSB = 11;
	localparam int unsigned SEL_LSB  = 12;	// compare bit select
	localparam int unsigned SEL_MSB  = 15;

	// major opcodes, anything else is undefined
	typedef enum logic [5:0] {
		OP_R2    = 6'h02,	// register form, see func_e
		OP_ADDI  = 6'h04,
		OP_SUBFI = 6'h05,	// imm - a
		OP_ANDI  = 6'h08,
		OP_ORI   = 6'h09,
		OP_XORI  = 6'h0A,
		OP_CMPI  = 6'h0B,
		OP_FCMPI = 6'h0C
	} opcode_e;

	// sub-functions of OP_R2
	typedef enum logic [5:0] {
		F_ADD     = 6'h04,
		F_SUB     = 6'h05,
		F_AND     = 6'h08,
		F_OR      = 6'h09,
		F_XOR     = 6'h0A,
		F_SLL     = 6'h10,
		F_SRL     = 6'h11,
		F_SRA     = 6'h12,
		F_SLLI    = 6'h14,	// amount from imm
		F_SRLI    = 6'h15,
		F_SRAI    = 6'h16,
		F_CMP     = 6'h18,
		F_FCMP    = 6'h19,
		F_CNTLZ   = 6'h20,
		F_CNTPOP  = 6'h21,
		F_SEXTB   = 6'h24,
		F_SEXTW   = 6'h25,	// half-word
		F_FABS    = 6'h28,
		F_FNABS   = 6'h29,
		F_FNEG    = 6'h2A,
		F_FCLASS  = 6'h2B,
		F_FSIGN   = 6'h2C,
		F_FFINITE = 6'h2D
	} func_e;

	// operation handed to the integer unit
	typedef enum logic [3:0] {
		IOP_ADD, IOP_SUB, IOP_AND, IOP_OR, IOP_XOR,
		IOP_SLL, IOP_SRL, IOP_SRA,
		IOP_CMP,
		IOP_CNTLZ, IOP_CNTPOP,
		IOP_SEXTB, IOP_SEXTW
	} int_op_e;

	// operation handed to the float unit
	typedef enum logic [2:0] {
		FOP_ABS, FOP_NABS, FOP_NEG, FOP_CLASS, FOP_SIGN, FOP_FINITE, FOP_CMP
	} fp_op_e;

endpackage

`default_nettype wire

//--- verilog/phx_value_pkg.sv
`default_nettype none

package phx_value_pkg;

	// ========================================================================
	// operand geometry
	// ========================================================================
	localparam int unsigned XLEN    = 32;	// operand and result width
	localparam int unsigned SHIFT_W = $clog2(XLEN);	// shift amount bits
	localparam int unsigned CNT_W   = $clog2(XLEN) + 1;	// count has to reach XLEN
	localparam int unsigned EXP_W   = 8;	// single precision exponent
	localparam int unsigned FRAC_W  = 23;	// single precision fraction

	typedef logic [XLEN-1:0]   value_t;	// one operand or result
	typedef logic [2*XLEN-1:0] dvalue_t;	// double width, used by the shifter
	typedef logic [CNT_W-1:0]  count_t;	// cntlz / cntpop result

	localparam value_t FP_ONE     = 32'h3F80_0000;	// +1.0
	localparam value_t FP_NEG_ONE = 32'hBF80_0000;	// -1.0

	// integer compare vector bit positions, other bits read zero
	localparam int unsigned CMP_EQ  = 0;
	localparam int unsigned CMP_LT  = 1;	// signed
	localparam int unsigned CMP_LE  = 2;
	localparam int unsigned CMP_LTU = 5;	// unsigned
	localparam int unsigned CMP_LEU = 6;
	localparam int unsigned CMP_NE  = 8;
	localparam int unsigned CMP_GE  = 9;
	localparam int unsigned CMP_GT  = 10;
	localparam int unsigned CMP_GEU = 13;
	localparam int unsigned CMP_GTU = 14;

	// float compare vector bit positions
	localparam int unsigned FCMP_EQ  = 0;
	localparam int unsigned FCMP_LT  = 1;
	localparam int unsigned FCMP_LE  = 2;
	localparam int unsigned FCMP_UNE = 5;	// unordered or not equal
	localparam int unsigned FCMP_GE  = 9;
	localparam int unsigned FCMP_GT  = 10;
	localparam int unsigned FCMP_MGE = 11;	// |a| >= |b|
	localparam int unsigned FCMP_ORD = 12;	// neither is a NaN

	localparam logic [3:0] SEL_ALL = 4'd15;	// select value: whole vector

endpackage

`default_nettype wire
